//--- isc0901_capture.f
+incdir+design
design/isc_pkg.sv
design/sensor_timing_gen.sv
design/pixel_deserializer.sv
design/stream_packer.sv
design/isc0901_capture.sv
bench/tb_isc0901_capture.sv

//--- run_sim.sh
#!/bin/sh
# build and run the isc0901 capture testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f isc0901_capture.f --top-module tb_isc0901_capture
status=0
out=$(./obj_dir/Vtb_isc0901_capture 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1

//--- bench/tb_isc0901_capture.sv
// isc0901 capture testbench: directed checks of reset, image beats, pixels, rtemp and sof
`timescale 1ns/1ps
`include "isc_settings.svh"

module tb_isc0901_capture
    import isc_pkg::*;
();

    localparam int res_x        = 8;    // shrunk geometry
    localparam int res_y        = 4;
    localparam int line_period  = 100;
    localparam int frame_period = 1000;
    localparam int sof_lead     = 50;
    localparam int half_x       = res_x / 2;   // beats per row
    localparam int bpp          = `ISC_BITS_PER_PIXEL;
    localparam int max_cycles   = 5 * frame_period; // reset, one frame, two frames for sof, margin

    logic         clk;
    logic         aresetn;
    logic         sensor_data_odd;
    logic         sensor_data_even;
    stream_word_t img;
    stream_word_t rtemp;
    logic         sof;
    logic         eol;

    pixel_pair_t  hist;        // last 14 sampled bits per line
    pixel_pair_t  hist_prev;   // same, one cycle older
    int           errors = 0;
    int           checks = 0;
    int           cycle_count = 0;

    isc0901_capture #(
        .res_x        (res_x),
        .res_y        (res_y),
        .line_period  (line_period),
        .frame_period (frame_period),
        .sof_lead     (sof_lead)
    ) DUT (
        .clk              (clk),
        .aresetn          (aresetn),
        .sensor_data_odd  (sensor_data_odd),
        .sensor_data_even (sensor_data_even),
        .img              (img),
        .rtemp            (rtemp),
        .sof              (sof),
        .eol              (eol)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // serial bits change on the falling edge
    initial begin
        logic [31:0] rnd;
        sensor_data_odd  = 1'b0;
        sensor_data_even = 1'b0;
        rnd = $urandom(32'h24fd_0b8f); // seed once
        forever begin
            @(negedge clk);
            rnd = $urandom();
            sensor_data_odd  = rnd[0];
            sensor_data_even = rnd[1];
        end
    end

    // reference history, newest bit enters at the top
    always @(posedge clk) begin
        hist_prev <= hist;
        hist.odd  <= {sensor_data_odd, hist.odd[bpp-1:1]};
        hist.even <= {sensor_data_even, hist.even[bpp-1:1]};
    end

    task automatic check_pair(input string name, input pixel_pair_t exp, input pixel_pair_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // fixed fields only: valid, last and the pad bits
    task automatic check_word(input string name, input stream_word_t exp,
                              input stream_word_t act);
        logic [31:0] pad_mask;
        pad_mask = 32'hc000_c000;  // two pad bits above each pixel
        checks++;
        if (act.valid !== exp.valid || act.last !== exp.last
            || (act.data & pad_mask) !== (exp.data & pad_mask)) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic reset_state();
        repeat (10) begin
            @(negedge clk);
            check_count("reset_state", 0, int'({sof, eol, img.valid, img.last, rtemp.valid}));
        end
        aresetn = 1'b1;  // release on falling edge
        @(negedge clk);
        check_count("reset_state first cycle", 0,
                    int'({sof, eol, img.valid, img.last, rtemp.valid}));
    endtask

    task automatic image_beat_counts();
        stream_word_t exp_word;
        int beats;
        int lasts;
        beats = 0;
        lasts = 0;
        repeat (frame_period) begin
            @(negedge clk);
            if (img.last) lasts++;  // counted on any cycle
            if (img.valid) begin
                exp_word.data  = '0;
                exp_word.valid = 1'b1;
                exp_word.last  = (beats % half_x == half_x - 1); // every fourth beat
                check_word("image_beat_counts", exp_word, img);
                beats++;
            end
        end
        check_count("image_beat_counts beats", half_x * res_y, beats);
        check_count("image_beat_counts lasts", res_y, lasts);
    endtask

    task automatic pixel_content();
        pixel_pair_t got;
        int beats;
        beats = 0;
        repeat (frame_period) begin
            @(negedge clk);
            if (img.valid) begin
                got.odd  = img.data[16 +: bpp];
                got.even = img.data[0 +: bpp];
                check_pair("pixel_content", hist_prev, got);
                check_count("pixel_content pad bits", 0,
                            int'({img.data[31:30], img.data[15:14]}));
                beats++;
            end
        end
        check_count("pixel_content beats", half_x * res_y, beats); // pixels really compared
    endtask

    task automatic row_temperature();
        stream_word_t exp_word;
        pixel_pair_t  got;
        int beats;
        beats = 0;
        repeat (frame_period) begin
            @(negedge clk);
            check_count("row_temperature eol", int'(rtemp.valid), int'(eol));
            if (rtemp.valid) begin
                exp_word.data  = '0;
                exp_word.valid = 1'b1;
                exp_word.last  = 1'b1;  // one beat per line
                check_word("row_temperature", exp_word, rtemp);
                got.odd  = rtemp.data[16 +: bpp];
                got.even = rtemp.data[0 +: bpp];
                check_pair("row_temperature word", hist_prev, got); // bits right after the row
                beats++;
            end
        end
        check_count("row_temperature beats", res_y + `ISC_EXTRA_LINES, beats);
    endtask

    task automatic sof_spacing();
        int waited;
        int gap;
        waited = 0;
        gap    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (sof !== 1'b1 && waited < 2 * frame_period);
        if (sof !== 1'b1) begin
            errors++;
            $display("sof_spacing: no sof pulse seen within %0d cycles", waited);
        end else begin
            do begin
                @(negedge clk);
                gap++;
            end while (sof !== 1'b1 && gap < 2 * frame_period);
            check_count("sof_spacing", frame_period, gap);
        end
    endtask

    initial begin
        aresetn = 1'b0;
        reset_state();
        fork  // all three watch the same frame
            image_beat_counts();
            pixel_content();
            row_temperature();
        join
        sof_spacing();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- design/isc0901_capture.sv
// isc0901 capture top: serial pixel capture with frame/line timing and output streams
`timescale 1ns/1ps
`include "isc_settings.svh"

module isc0901_capture
    import isc_pkg::*;
#(
    parameter int res_x        = `ISC_RES_X,
    parameter int res_y        = `ISC_RES_Y,
    parameter int line_period  = `ISC_LINE_PERIOD,
    parameter int frame_period = `ISC_FRAME_PERIOD,
    parameter int sof_lead     = `ISC_SOF_LEAD
) (
    input  logic         clk,
    input  logic         aresetn,
    input  logic         sensor_data_odd,
    input  logic         sensor_data_even,
    output stream_word_t img,
    output stream_word_t rtemp,
    output logic         sof,
    output logic         eol
);

    line_timing_t timing; // strobes, one cycle after counter match
    pixel_pair_t  pair;   // raw shift register contents

    sensor_timing_gen #(
        .res_x        (res_x),
        .res_y        (res_y),
        .line_period  (line_period),
        .frame_period (frame_period),
        .sof_lead     (sof_lead)
    ) u_timing (
        .clk     (clk),
        .aresetn (aresetn),
        .timing  (timing),
        .sof     (sof)
    );

    pixel_deserializer u_deser (
        .clk              (clk),
        .aresetn          (aresetn),
        .sensor_data_odd  (sensor_data_odd),
        .sensor_data_even (sensor_data_even),
        .pair             (pair)
    );

    stream_packer u_packer (
        .clk     (clk),
        .aresetn (aresetn),
        .timing  (timing),
        .pair    (pair),
        .img     (img),
        .rtemp   (rtemp),
        .eol     (eol)
    );

endmodule

//--- design/stream_packer.sv
// stream packer: latches pixel pairs on timing strobes into image and row temperature beats
`timescale 1ns/1ps

module stream_packer
    import isc_pkg::*;
(
    input  logic         clk,
    input  logic         aresetn,
    input  line_timing_t timing,
    input  pixel_pair_t  pair,
    output stream_word_t img,
    output stream_word_t rtemp,
    output logic         eol
);

    logic [31:0] pair_word;   // 16-bit aligned pair
    logic [31:0] img_data;
    logic [31:0] rtemp_data;
    logic        img_valid;
    logic        img_last;
    logic        rtemp_valid;
    logic        img_hit;     // visible pixel strobe

    assign pair_word = {2'b00, pair.odd, 2'b00, pair.even};
    assign img_hit   = timing.pixel_strobe && timing.pixel_visible;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            img_valid   <= 1'b0;
            img_last    <= 1'b0;
            rtemp_valid <= 1'b0;
        end else begin
            img_valid   <= img_hit;
            img_last    <= timing.pixel_visible && timing.pixel_last; // extra lines give no last
            rtemp_valid <= timing.rtemp_strobe;
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (timing.pixel_strobe) begin
            img_data <= pair_word;
        end
        if (timing.rtemp_strobe) begin
            rtemp_data <= pair_word;
        end
    end

    assign img   = '{data: img_data, valid: img_valid, last: img_last};
    assign rtemp = '{data: rtemp_data, valid: rtemp_valid, last: rtemp_valid}; // one beat per line
    assign eol   = rtemp_valid; // rtemp closes every line

    // timing gen gives last only together with a pixel strobe
    img_last_needs_valid: assert property (@(posedge clk) disable iff (!aresetn)
        img.last |-> img.valid);

endmodule

//--- design/pixel_deserializer.sv
// pixel deserializer: two lsb-first shift registers for the odd and even serial lines
`timescale 1ns/1ps
`include "isc_settings.svh"

module pixel_deserializer
    import isc_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        sensor_data_odd,
    input  logic        sensor_data_even,
    output pixel_pair_t pair
);

    localparam int bpp = `ISC_BITS_PER_PIXEL;

    pixel_pair_t shreg; // free-running, framing comes from the timing gen

    // sensor drives on falling edge, sample on rising
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            shreg <= '0;
        end else begin
            shreg.odd  <= {sensor_data_odd,  shreg.odd[bpp-1:1]};  // newest bit at msb
            shreg.even <= {sensor_data_even, shreg.even[bpp-1:1]}; // oldest ends in bit 0
        end
    end

    // no extra stage, packer samples on the strobe
    assign pair = shreg;

endmodule

//--- design/sensor_timing_gen.sv
// sensor timing generator: frame and line counters producing pixel, rtemp and sof strobes
`timescale 1ns/1ps
`include "isc_settings.svh"

module sensor_timing_gen
    import isc_pkg::*;
#(
    parameter int res_x        = `ISC_RES_X,
    parameter int res_y        = `ISC_RES_Y,
    parameter int line_period  = `ISC_LINE_PERIOD,
    parameter int frame_period = `ISC_FRAME_PERIOD,
    parameter int sof_lead     = `ISC_SOF_LEAD
) (
    input  logic         clk,
    input  logic         aresetn,
    output line_timing_t timing,
    output logic         sof
);

    localparam int bpp           = `ISC_BITS_PER_PIXEL;
    localparam int line_num      = res_y + `ISC_EXTRA_LINES;       // extra lines included
    localparam int full_row_tics = (res_x / 2 + 1) * bpp;          // row plus one preamble pixel
    localparam int rtemp_tic     = (res_x / 2 + 2) * bpp + 1;      // rtemp word fully shifted in
    localparam int sof_tic       = frame_period - sof_lead;
    localparam int frame_w       = $clog2(frame_period);
    localparam int line_w        = $clog2(line_period);
    localparam int cnt_w         = $clog2(line_num + 1);
    localparam int num_w         = $clog2(res_x / 2 + 1);
    localparam int phase_w       = $clog2(bpp);

    logic [frame_w-1:0] frame_tc;   // cycle within frame
    logic [line_w-1:0]  line_tc;    // cycle within line
    logic [cnt_w-1:0]   line_cnt;   // line within frame, saturates at line_num
    logic               line_wnd;   // row incl. preamble is on the wires
    logic [phase_w-1:0] pixel_tc;   // bit position inside current pixel
    logic [num_w-1:0]   pixel_num;  // pair index in row
    logic               pixel_valid;
    logic               pixel_last;
    logic               pixel_visible;
    logic               rtemp_valid;

    logic               pixel_wnd;  // preamble skipped, any line
    logic               data_wnd;   // same, image lines only

    assign pixel_wnd = line_wnd && (line_tc > line_w'(bpp + 1));
    assign data_wnd  = pixel_wnd && (line_cnt >= cnt_w'(`ISC_EXTRA_LINES));

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_tc      <= '0;
            line_tc       <= '0;
            line_cnt      <= '0;
            line_wnd      <= 1'b0;
            pixel_tc      <= '0;
            pixel_num     <= '0;
            pixel_valid   <= 1'b0;
            pixel_last    <= 1'b0;
            pixel_visible <= 1'b0;
            rtemp_valid   <= 1'b0;
            sof           <= 1'b0;
        end else begin
            if (frame_tc == frame_w'(frame_period - 1)) begin // wrap at frame end
                frame_tc <= '0;
            end else begin
                frame_tc <= frame_tc + 1'b1;
            end

            if (frame_tc > frame_w'(`ISC_LINE_START - 1)) begin // line timing active
                if (line_tc == line_w'(line_period - 1)) begin
                    line_tc <= '0;
                    if (line_cnt < cnt_w'(line_num)) begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end else begin
                    line_tc <= line_tc + 1'b1;
                end
            end else begin
                line_tc  <= '0; // held during frame lead-in
                line_cnt <= '0;
            end

            line_wnd <= (line_tc > '0) && (line_tc <= line_w'(full_row_tics))
                        && (line_cnt < cnt_w'(line_num));

            if (pixel_wnd) begin
                if (pixel_tc == phase_w'(bpp - 1)) begin // 14th bit in
                    pixel_tc    <= '0;
                    pixel_valid <= 1'b1;
                    pixel_num   <= pixel_num + 1'b1;
                    pixel_last  <= (pixel_num == num_w'(res_x / 2 - 1));
                end else begin
                    pixel_tc    <= pixel_tc + 1'b1;
                    pixel_valid <= 1'b0;
                    pixel_last  <= 1'b0;
                end
            end else begin
                pixel_tc    <= '0;
                pixel_num   <= '0;
                pixel_valid <= 1'b0;
                pixel_last  <= 1'b0;
            end

            pixel_visible <= data_wnd;  // aligned with pixel_valid
            rtemp_valid   <= (line_tc == line_w'(rtemp_tic)) && (line_cnt < cnt_w'(line_num));
            sof           <= (frame_tc == frame_w'(sof_tic));
        end
    end

    assign timing = '{
        pixel_strobe:  pixel_valid,
        pixel_last:    pixel_last,
        pixel_visible: pixel_visible,
        rtemp_strobe:  rtemp_valid
    };

    // line count stays inside the frame
    line_cnt_bound: assert property (@(posedge clk) disable iff (!aresetn)
        line_cnt <= cnt_w'(line_num));

    // rtemp slot lies after the pixel window
    strobe_exclusive: assert property (@(posedge clk) disable iff (!aresetn)
        !(timing.pixel_strobe && timing.rtemp_strobe));

endmodule

//--- design/isc_pkg.sv
// isc0901 capture package: packed structs shared between blocks and the testbench
`include "isc_settings.svh"

package isc_pkg;

    // one odd/even pixel pair as seen on the two serial lines
    typedef struct packed {
        logic [`ISC_BITS_PER_PIXEL-1:0] odd;   // odd line pixel
        logic [`ISC_BITS_PER_PIXEL-1:0] even;  // even line pixel
    } pixel_pair_t;

    // per-cycle strobes from the timing generator
    typedef struct packed {
        logic pixel_strobe;   // whole pixel sits in the shift registers
        logic pixel_last;     // last pixel pair of the row
        logic pixel_visible;  // row is image content, not an extra line
        logic rtemp_strobe;   // row temperature word in the shift registers
    } line_timing_t;

    // output beat, valid-qualified, no back-pressure
    typedef struct packed {
        logic [31:0] data;  // {2'b0, odd, 2'b0, even}
        logic        valid; // one-cycle pulse
        logic        last;  // end of row
    } stream_word_t;

endpackage

//--- design/isc_settings.svh
// isc0901 capture settings: sensor geometry, pixel depth, frame and line timing
`ifndef ISC_SETTINGS_SVH
`define ISC_SETTINGS_SVH

// serial bits per pixel on each data line, lsb first
`define ISC_BITS_PER_PIXEL 14

// leading lines with no image content, they still carry a row temperature
`define ISC_EXTRA_LINES 3

// cycles after frame start before line timing begins
`define ISC_LINE_START 202

// visible resolution
`define ISC_RES_X 336
`define ISC_RES_Y 256

// line period in system clocks, 73.636 MHz nominal
`define ISC_LINE_PERIOD 4676

// whole frame period in system clocks
`define ISC_FRAME_PERIOD 1228500

// sof fires this many cycles before the frame counter wraps
`define ISC_SOF_LEAD 6500

`endif
